// File: rtl/rvPkg.sv
/* Shared RV32I definitions for the single-cycle core.
   Opcodes, instruction-word views, control strobes and ALU codes. */
package rvPkg;

    // Major opcodes of the supported instructions.
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opReg    = 7'b0110011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opJal    = 7'b1101111;

    // Field layouts, MSB first.
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rFmtT;

    typedef struct packed {
        logic [11:0] imm11to0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iFmtT;

    typedef struct packed {
        logic [6:0] imm11to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm4to0;
        logic [6:0] opcode;
    } sFmtT;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bFmtT;

    // Also carries the scrambled J immediate.
    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uFmtT;

    // One instruction word, five ways to read it.
    typedef union packed {
        rFmtT r;
        iFmtT i;
        sFmtT s;
        bFmtT b;
        uFmtT u;
    } instrT;

    typedef enum logic [1:0] {
        src1Rs1  = 2'b00,
        src1Zero = 2'b01,
        src1Pc   = 2'b10
    } aluSrc1T;

    typedef enum logic [1:0] {
        src2Rs2  = 2'b00,
        src2Imm  = 2'b01,
        src2Four = 2'b11
    } aluSrc2T;

    // Operation class, refined by funct3/funct7 inside the ALU.
    typedef enum logic [1:0] {
        aluAdd    = 2'b00,
        aluBranch = 2'b01,
        aluReg    = 2'b10,
        aluImm    = 2'b11
    } aluOpT;

    typedef struct packed {
        logic    jump;
        logic    jumpReg;
        logic    branch;
        logic    memRead;
        logic    memWrite;
        logic    memToReg;
        logic    regWrite;
        aluSrc1T aluSrc1;
        aluSrc2T aluSrc2;
        aluOpT   aluOp;
    } ctrlT;

endpackage

// File: rtl/controlUnit.sv
/* Main decoder of the core.
   Maps the opcode to control strobes and ALU operand and operation codes. */
module controlUnit (
    input  logic [6:0]  opCode,
    input  logic        enable,
    output rvPkg::ctrlT ctrl
);

    always_comb begin : decode
        // Everything inactive unless a known opcode says otherwise.
        ctrl.jump     = 1'b0;
        ctrl.jumpReg  = 1'b0;
        ctrl.branch   = 1'b0;
        ctrl.memRead  = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.memToReg = 1'b0;
        ctrl.regWrite = 1'b0;
        ctrl.aluSrc1  = rvPkg::src1Rs1;
        ctrl.aluSrc2  = rvPkg::src2Rs2;
        ctrl.aluOp    = rvPkg::aluAdd;

        // A stalled core decodes as a no-op.
        if (enable) begin
            case (opCode)
                rvPkg::opLoad: begin
                    ctrl.aluSrc2  = rvPkg::src2Imm;
                    ctrl.memRead  = 1'b1;
                    ctrl.memToReg = 1'b1;
                    ctrl.regWrite = 1'b1;
                end
                rvPkg::opImm: begin
                    ctrl.aluSrc2  = rvPkg::src2Imm;
                    ctrl.aluOp    = rvPkg::aluImm;
                    ctrl.regWrite = 1'b1;
                end
                rvPkg::opAuipc: begin
                    ctrl.aluSrc1  = rvPkg::src1Pc;
                    ctrl.aluSrc2  = rvPkg::src2Imm;
                    ctrl.regWrite = 1'b1;
                end
                rvPkg::opStore: begin
                    // Address is rs1 + imm, data is rs2.
                    ctrl.aluSrc2  = rvPkg::src2Imm;
                    ctrl.memWrite = 1'b1;
                end
                rvPkg::opReg: begin
                    ctrl.aluOp    = rvPkg::aluReg;
                    ctrl.regWrite = 1'b1;
                end
                rvPkg::opLui: begin
                    // Zero plus the upper immediate.
                    ctrl.aluSrc1  = rvPkg::src1Zero;
                    ctrl.aluSrc2  = rvPkg::src2Imm;
                    ctrl.regWrite = 1'b1;
                end
                rvPkg::opBranch: begin
                    ctrl.branch = 1'b1;
                    ctrl.aluOp  = rvPkg::aluBranch;
                end
                rvPkg::opJalr: begin
                    // ALU forms the link value pc + 4.
                    ctrl.jumpReg  = 1'b1;
                    ctrl.aluSrc1  = rvPkg::src1Pc;
                    ctrl.aluSrc2  = rvPkg::src2Four;
                    ctrl.regWrite = 1'b1;
                end
                rvPkg::opJal: begin
                    ctrl.jump     = 1'b1;
                    ctrl.aluSrc1  = rvPkg::src1Pc;
                    ctrl.aluSrc2  = rvPkg::src2Four;
                    ctrl.regWrite = 1'b1;
                end
                default: begin
                    // Unknown opcode leaves all strobes low.
                end
            endcase
        end
    end

endmodule

// File: rtl/immGen.sv
/* Immediate generator.
   Builds the sign-extended I, S, B, U or J immediate from the opcode. */
module immGen (
    input  rvPkg::instrT instr,
    output logic [31:0]  imm
);

    always_comb begin : build
        case (instr.r.opcode)
            rvPkg::opImm, rvPkg::opLoad, rvPkg::opJalr: begin
                imm = {{20{instr.i.imm11to0[11]}}, instr.i.imm11to0};
            end
            rvPkg::opStore: begin
                imm = {{20{instr.s.imm11to5[6]}}, instr.s.imm11to5, instr.s.imm4to0};
            end
            rvPkg::opBranch: begin
                // Offset in halfwords, bit 0 always zero.
                imm = {{20{instr.b.imm12}}, instr.b.imm11, instr.b.imm10to5,
                       instr.b.imm4to1, 1'b0};
            end
            rvPkg::opLui, rvPkg::opAuipc: begin
                imm = {instr.u.imm, 12'd0};
            end
            rvPkg::opJal: begin
                // Bits 31, 30:21, 20 and 19:12 hold imm[20], [10:1], [11] and [19:12].
                imm = {{12{instr.u.imm[19]}}, instr.u.imm[7:0], instr.u.imm[8],
                       instr.u.imm[18:9], 1'b0};
            end
            default: begin
                imm = 32'd0;
            end
        endcase
    end

endmodule

// File: rtl/regFile.sv
/* Integer register file, x1 to x31 in flops with x0 tied to zero.
   Two combinational read ports and one write port at the clock edge. */
module regFile (
    input  logic        clk,
    input  logic        arstN,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic        we,
    input  logic [31:0] wdata,
    output logic [31:0] rs1Data,
    output logic [31:0] rs2Data
);

    // No storage behind x0.
    logic [31:0] regs [1:31];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int idx = 1; idx < 32; idx++) begin
                regs[idx] <= 32'd0;
            end
        end else if (we && (rd != 5'd0)) begin
            regs[rd] <= wdata;
        end
    end

    // Reads of x0 return zero.
    assign rs1Data = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
    assign rs2Data = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

// File: rtl/alu.sv
/* ALU with operand selection.
   Arithmetic, logic, shifts and compares, plus the branch condition. */
module alu (
    input  rvPkg::ctrlT  ctrl,
    input  rvPkg::instrT instr,
    input  logic [31:0]  rs1Data,
    input  logic [31:0]  rs2Data,
    input  logic [31:0]  pc,
    input  logic [31:0]  imm,
    output logic [31:0]  result,
    output logic         taken
);

    logic [31:0] opA;
    logic [31:0] opB;
    logic [2:0]  funct3;
    logic        alt;

    assign funct3 = instr.r.funct3;
    // funct7[5] picks SUB and SRA; for immediates it is imm[10].
    assign alt    = instr.r.funct7[5];

    always_comb begin : operands
        case (ctrl.aluSrc1)
            rvPkg::src1Zero: opA = 32'd0;
            rvPkg::src1Pc:   opA = pc;
            default:         opA = rs1Data;
        endcase
        case (ctrl.aluSrc2)
            rvPkg::src2Imm:  opB = imm;
            rvPkg::src2Four: opB = 32'd4;
            default:         opB = rs2Data;
        endcase
    end

    always_comb begin : compute
        result = opA + opB;
        taken  = 1'b0;
        case (ctrl.aluOp)
            rvPkg::aluReg, rvPkg::aluImm: begin
                case (funct3)
                    // SUB exists only in the register form.
                    3'b000: result = (alt && ctrl.aluOp == rvPkg::aluReg) ? opA - opB
                                                                          : opA + opB;
                    3'b001: result = opA << opB[4:0];
                    3'b010: result = {31'd0, $signed(opA) < $signed(opB)};
                    3'b011: result = {31'd0, opA < opB};
                    3'b100: result = opA ^ opB;
                    3'b101: result = alt ? 32'($signed(opA) >>> opB[4:0]) : opA >> opB[4:0];
                    3'b110: result = opA | opB;
                    default: result = opA & opB;
                endcase
            end
            rvPkg::aluBranch: begin
                result = opA - opB;
                case (funct3)
                    3'b000: taken = (opA == opB);
                    3'b001: taken = (opA != opB);
                    3'b100: taken = ($signed(opA) < $signed(opB));
                    3'b101: taken = ($signed(opA) >= $signed(opB));
                    3'b110: taken = (opA < opB);
                    3'b111: taken = (opA >= opB);
                    default: taken = 1'b0;
                endcase
            end
            default: begin
                // Plain add for addresses, LUI, AUIPC and link values.
            end
        endcase
    end

endmodule

// File: rtl/rvCore.sv
/* Single-cycle RV32I core top level.
   Holds the PC, next-PC selection, writeback and the memory ports. */
module rvCore #(
    parameter logic [31:0] resetPc = 32'd0
) (
    input  logic         clk,
    input  logic         arstN,
    input  logic         enable,
    // Instruction fetch, combinational.
    output logic [31:0]  instrAddr,
    input  rvPkg::instrT instr,
    // Data memory.
    output logic [31:0]  dataAddr,
    output logic [31:0]  dataWdata,
    output logic         dataWe,
    output logic         dataRe,
    input  logic [31:0]  dataRdata,
    // Copy of the register write port.
    output logic         retireWe,
    output logic [4:0]   retireRd,
    output logic [31:0]  retireData
);

    rvPkg::ctrlT ctrl;
    logic [31:0] pc;
    logic [31:0] nextPc;
    logic [31:0] imm;
    logic [31:0] rs1Data;
    logic [31:0] rs2Data;
    logic [31:0] aluResult;
    logic        taken;
    logic [31:0] jalrTarget;
    logic [31:0] wbData;

    controlUnit controlUnit_i (
        .opCode (instr.r.opcode),
        .enable (enable),
        .ctrl   (ctrl)
    );

    immGen immGen_i (
        .instr (instr),
        .imm   (imm)
    );

    // Write enable is already low while stalled.
    regFile regFile_i (
        .clk     (clk),
        .arstN   (arstN),
        .rs1     (instr.r.rs1),
        .rs2     (instr.r.rs2),
        .rd      (instr.r.rd),
        .we      (ctrl.regWrite),
        .wdata   (wbData),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    alu alu_i (
        .ctrl    (ctrl),
        .instr   (instr),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .pc      (pc),
        .imm     (imm),
        .result  (aluResult),
        .taken   (taken)
    );

    // ALU is busy with the link value on JALR.
    assign jalrTarget = (rs1Data + imm) & ~32'd1;

    always_comb begin : pcSelect
        if (ctrl.jumpReg) begin
            nextPc = jalrTarget;
        end else if (ctrl.jump || (ctrl.branch && taken)) begin
            nextPc = pc + imm;
        end else begin
            nextPc = pc + 32'd4;
        end
    end

    // PC only moves on enabled cycles.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= resetPc;
        end else if (enable) begin
            pc <= nextPc;
        end
    end

    assign wbData = ctrl.memToReg ? dataRdata : aluResult;

    assign instrAddr  = pc;
    assign dataAddr   = aluResult;
    assign dataWdata  = rs2Data;
    assign dataWe     = ctrl.memWrite;
    assign dataRe     = ctrl.memRead;
    assign retireWe   = ctrl.regWrite;
    assign retireRd   = instr.r.rd;
    assign retireData = wbData;

endmodule

// File: tests/clockGen.sv
/* Testbench clock and reset source.
   Free-running clock, reset held low over the first four rising edges. */
module clockGen #(
    parameter int period = 40
) (
    output logic clk,
    output logic arstN
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin : clockProc
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // Released shortly after a falling edge, away from both clock edges.
    initial begin : resetProc
        arstN = 1'b0;
        #(4 * period + period / 8);
        arstN = 1'b1;
    end

endmodule

// File: tests/rvCoreTb.sv
/* Testbench for the single-cycle RV32I core.
   Random instruction stream checked every cycle against an ISA model. */
module rvCoreTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int clkPeriod = 40;
    localparam int numCycles = 3000;

    logic         clk;
    logic         arstN;
    logic         enable;
    rvPkg::instrT instr;
    logic [31:0]  instrAddr;
    logic [31:0]  dataAddr;
    logic [31:0]  dataWdata;
    logic         dataWe;
    logic         dataRe;
    logic [31:0]  dataRdata;
    logic         retireWe;
    logic [4:0]   retireRd;
    logic [31:0]  retireData;

    // Model PC, registers, 256-word data memory and 1 KB code window.
    logic [31:0] lfsr;
    logic [31:0] modelPc;
    logic [31:0] modelRegs [0:31];
    logic [31:0] dmem [0:255];
    logic [31:0] codeMem [0:255];
    logic        codeValid [0:255];
    int          errors;

    clockGen #(.period(clkPeriod)) clockGen_i (.clk(clk), .arstN(arstN));

    rvCore #(.resetPc(32'd0)) rvCore_i (
        .clk        (clk),
        .arstN      (arstN),
        .enable     (enable),
        .instrAddr  (instrAddr),
        .instr      (instr),
        .dataAddr   (dataAddr),
        .dataWdata  (dataWdata),
        .dataWe     (dataWe),
        .dataRe     (dataRe),
        .dataRdata  (dataRdata),
        .retireWe   (retireWe),
        .retireRd   (retireRd),
        .retireData (retireData)
    );

    // Combinational read by word index.
    assign dataRdata = dmem[dataAddr[9:2]];

    // Fibonacci LFSR with taps 32, 22, 2 and 1.
    function automatic logic stepLfsr();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = 32'd0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], stepLfsr()};
        end
        return v;
    endfunction

    // Picks a register that holds a small address, or x0 when it does not.
    function automatic logic [4:0] pickBase();
        logic [4:0] r;
        r = 5'(randBits(5));
        return (modelRegs[r] < 32'd1024) ? r : 5'd0;
    endfunction

    function automatic logic [31:0] genInstr(input logic [31:0] pc);
        rvPkg::instrT w;
        logic [3:0]  kind;
        logic [4:0]  base;
        logic [31:0] off;
        w = randBits(32);
        kind = 4'(randBits(4));
        base = pickBase();
        // Last word of the window always jumps back.
        if (pc == 32'd1020) begin
            kind = 4'd11;
        end
        case (kind)
            4'd0, 4'd1, 4'd2: begin
                w.i.opcode = rvPkg::opImm;
                // Shifts keep only the SRAI bit above shamt.
                if (w.i.funct3[1:0] == 2'b01) begin
                    w.r.funct7 = {1'b0, w.r.funct7[5] & w.i.funct3[2], 5'd0};
                end
            end
            4'd3, 4'd4, 4'd15: begin
                w.r.opcode = rvPkg::opReg;
                w.r.funct7 = {1'b0, w.r.funct7[5] &
                              (w.r.funct3 == 3'b000 || w.r.funct3 == 3'b101), 5'd0};
            end
            4'd5: w.u.opcode = rvPkg::opLui;
            4'd6: w.u.opcode = rvPkg::opAuipc;
            4'd7, 4'd8: begin
                off = (randBits(8) << 2) - modelRegs[base];
                w.i.rs1 = base;
                w.i.funct3 = 3'b010;
                if (kind == 4'd7) begin
                    w.i.opcode = rvPkg::opLoad;
                    w.i.imm11to0 = off[11:0];
                end else begin
                    w.s.opcode = rvPkg::opStore;
                    w.s.imm11to5 = off[11:5];
                    w.s.imm4to0 = off[4:0];
                end
            end
            4'd9, 4'd10: begin
                off = (randBits(8) << 2) - pc;
                w.b.opcode = rvPkg::opBranch;
                // Funct3 010 and 011 are not branches.
                if (w.b.funct3[2:1] == 2'b01) begin
                    w.b.funct3[2:1] = 2'b00;
                end
                w.b.imm12 = off[12];
                w.b.imm11 = off[11];
                w.b.imm10to5 = off[10:5];
                w.b.imm4to1 = off[4:1];
            end
            4'd11: begin
                off = (randBits(8) << 2) - pc;
                w.u.opcode = rvPkg::opJal;
                w.u.imm = {off[20], off[10:1], off[11], off[19:12]};
            end
            4'd12: begin
                // Odd targets exercise the cleared bit 0.
                off = ((randBits(8) << 2) | randBits(1)) - modelRegs[base];
                w.i.opcode = rvPkg::opJalr;
                w.i.funct3 = 3'b000;
                w.i.rs1 = base;
                w.i.imm11to0 = off[11:0];
            end
            4'd13: w.r.opcode = randBits(1) ? 7'b0001111 : 7'b1110011;
            default: begin
                // ADDI from x0 seeds small base addresses.
                w.i.opcode = rvPkg::opImm;
                w.i.funct3 = 3'b000;
                w.i.rs1 = 5'd0;
                w.i.imm11to0 = {2'b00, w.i.imm11to0[9:0]};
            end
        endcase
        return w;
    endfunction

    function automatic logic [31:0] computeOp(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] x, input logic [31:0] y);
        logic [4:0] sh;
        sh = y[4:0];
        case (f3)
            3'b000: return alt ? x - y : x + y;
            3'b001: return x << sh;
            3'b010: return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'b011: return (x < y) ? 32'd1 : 32'd0;
            3'b100: return x ^ y;
            3'b101: return (alt && x[31]) ? ~((~x) >> sh) : x >> sh;
            3'b110: return x | y;
            default: return x & y;
        endcase
    endfunction

    task automatic reportMismatch(input string field, input logic [31:0] got,
                                  input logic [31:0] expected);
        errors++;
        $display("Mismatch at %0d ns: %s is %h, expected %h", $time, field, got, expected);
    endtask

    // Executes one instruction in the model and compares the DUT outputs.
    task automatic checkCycle(input logic [31:0] w, input logic en);
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] nextPc;
        logic        expWe;
        logic        expRe;
        logic        expRet;
        logic        take;
        f3 = w[14:12];
        rd = w[11:7];
        a = modelRegs[w[19:15]];
        b = modelRegs[w[24:20]];
        immI = {{20{w[31]}}, w[31:20]};
        res = 32'd0;
        addr = 32'd0;
        nextPc = modelPc + 32'd4;
        expWe = 1'b0;
        expRe = 1'b0;
        expRet = 1'b0;
        take = 1'b0;
        if (en) begin
            expRet = 1'b1;
            case (w[6:0])
                rvPkg::opLui: res = {w[31:12], 12'd0};
                rvPkg::opAuipc: res = modelPc + {w[31:12], 12'd0};
                rvPkg::opImm: res = computeOp(f3, w[30] && f3 == 3'b101, a, immI);
                rvPkg::opReg: res = computeOp(f3, w[30], a, b);
                rvPkg::opLoad: begin
                    addr = a + immI;
                    res = dmem[addr[9:2]];
                    expRe = 1'b1;
                end
                rvPkg::opStore: begin
                    addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                    expWe = 1'b1;
                    expRet = 1'b0;
                end
                rvPkg::opBranch: begin
                    case (f3)
                        3'b000: take = (a == b);
                        3'b001: take = (a != b);
                        3'b100: take = ($signed(a) < $signed(b));
                        3'b101: take = !($signed(a) < $signed(b));
                        3'b110: take = (a < b);
                        default: take = (a >= b);
                    endcase
                    if (take) begin
                        nextPc = modelPc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                    end
                    expRet = 1'b0;
                end
                rvPkg::opJal: begin
                    res = modelPc + 32'd4;
                    nextPc = modelPc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                end
                rvPkg::opJalr: begin
                    res = modelPc + 32'd4;
                    nextPc = (a + immI) & ~32'd1;
                end
                default: expRet = 1'b0;
            endcase
        end
        if (instrAddr !== modelPc) reportMismatch("instrAddr", instrAddr, modelPc);
        if (dataWe !== expWe) reportMismatch("dataWe", {31'd0, dataWe}, {31'd0, expWe});
        if (dataRe !== expRe) reportMismatch("dataRe", {31'd0, dataRe}, {31'd0, expRe});
        if (retireWe !== expRet) reportMismatch("retireWe", {31'd0, retireWe}, {31'd0, expRet});
        if (expRet && retireRd !== rd) reportMismatch("retireRd", {27'd0, retireRd}, {27'd0, rd});
        if (expRet && retireData !== res) reportMismatch("retireData", retireData, res);
        if ((expWe || expRe) && dataAddr !== addr) reportMismatch("dataAddr", dataAddr, addr);
        if (expWe && dataWdata !== b) reportMismatch("dataWdata", dataWdata, b);
        if (en) begin
            if (expWe) begin
                dmem[addr[9:2]] = b;
            end
            if (expRet && rd != 5'd0) begin
                modelRegs[rd] = res;
            end
            // Control flow is regenerated on the next visit so loops do not repeat.
            if (w[6:0] == rvPkg::opBranch || w[6:0] == rvPkg::opJal ||
                w[6:0] == rvPkg::opJalr) begin
                codeValid[modelPc[9:2]] = 1'b0;
            end
            modelPc = nextPc;
        end
    endtask

    initial begin : stimulus
        logic [31:0] word;
        logic        en;
        logic        afterReset;
        enable = 1'b0;
        instr = '0;
        lfsr = 32'h70e5;
        modelPc = 32'd0;
        errors = 0;
        afterReset = 1'b0;
        for (int k = 0; k < 32; k++) begin
            modelRegs[k] = 32'd0;
        end
        for (int k = 0; k < 256; k++) begin
            dmem[k] = (32'(k) * 32'h0001_0203) ^ 32'hc3a5_0000;
            codeValid[k] = 1'b0;
        end
        for (int cyc = 0; cyc < numCycles; cyc++) begin
            @(negedge clk);
            // Reset cycles and the first one after stay stalled on a random word.
            if (!arstN || afterReset) begin
                afterReset = !arstN;
                word = randBits(32);
                en = 1'b0;
            end else begin
                if (!codeValid[modelPc[9:2]]) begin
                    codeMem[modelPc[9:2]] = genInstr(modelPc);
                    codeValid[modelPc[9:2]] = 1'b1;
                end
                word = codeMem[modelPc[9:2]];
                en = (randBits(3) != 32'd0);
            end
            instr = word;
            enable = en;
            #(clkPeriod / 4);
            checkCycle(word, en);
        end
        $display("Run finished: %0d cycles, %0d errors", numCycles, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #((numCycles + 20) * clkPeriod);
        $display("Watchdog expired: the run did not end within %0d cycles", numCycles + 20);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: list.f
rtl/rvPkg.sv
rtl/controlUnit.sv
rtl/immGen.sv
rtl/regFile.sv
rtl/alu.sv
rtl/rvCore.sv
tests/clockGen.sv
tests/rvCoreTb.sv

// File: run.sh
#!/bin/sh
# Build and run the rvCore testbench with Verilator.
cd "$(dirname "$0")" || exit 1
logFile=sim.log

verilator --binary --timing --timescale 1ns/100ps --top-module rvCoreTb \
    -f list.f -o rvCoreSim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/rvCoreSim > "$logFile" 2>&1
status=$?
cat "$logFile"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The log decides the verdict.
if grep -q "TEST RESULT: FAIL" "$logFile"; then
    exit 1
fi
exit 0
